// File: immu_pkg.sv
`default_nettype none

package immu_pkg;

   // SPR map of the instruction MMU group
   localparam logic [15:0] SPR_IMMUCR_ADDR  = 16'h1000;
   localparam logic [15:0] SPR_ITLB_MR_BASE = 16'h1200;
   localparam logic [15:0] SPR_ITLB_TR_BASE = 16'h1280;
   localparam logic [15:0] SPR_ITLB_END     = 16'h1300;
   localparam logic [4:0]  SPR_GROUP_IMMU   = 5'd2;

   // 8 KiB pages
   localparam int PAGE_BITS = 13;

   typedef struct packed {
      logic [18:0] vpn;
      logic [10:0] reserved;
      logic        pl1;
      logic        valid;
   } itlb_match_t;

   typedef struct packed {
      logic [18:0] ppn;
      logic [4:0]  reserved;
      logic        uxe;
      logic        sxe;
      logic        dirty;
      logic        accessed;
      logic        wom;
      logic        wbc;
      logic        ci;
      logic        cc;
   } itlb_trans_t;

   // Second-level entry as stored in memory
   typedef struct packed {
      logic [18:0] ppn;
      logic [1:0]  reserved;
      logic        present;
      logic        l;
      logic        x;
      logic        w;
      logic        u;
      logic        d;
      logic        a;
      logic        wom;
      logic        wbc;
      logic        ci;
      logic        cc;
   } pte_t;

   typedef struct packed {
      logic [18:0] ptr;
      logic [12:0] unused;
   } pgd_t;

   // One memory word, seen as directory or table entry by walk level
   typedef union packed {
      pte_t pte;
      pgd_t pgd;
   } pt_word_u;

   typedef struct packed {
      logic        we;
      logic [5:0]  idx;
      logic [31:0] data;
   } tlb_wr_t;

   typedef struct packed {
      logic [31:0] phys_addr;
      logic        cache_inhibit;
      logic        tlb_miss;
      logic        exec_fault;
   } immu_result_t;

endpackage

`default_nettype wire

// File: tlb_ram.sv
`default_nettype none

module tlb_ram #(
   parameter int ADDR_WIDTH = 6,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] addr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

   // Write-first, the new word shows up on the next cycle
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= din_i;
         dout_o      <= din_i;
      end else begin
         dout_o <= mem[addr_i];
      end
   end

endmodule

`default_nettype wire

// File: immu_spr_regs.sv
`default_nettype none

module immu_spr_regs #(
   parameter int SET_WIDTH = 6
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              spr_stb_i,
   input  logic              spr_we_i,
   input  logic [15:0]       spr_addr_i,
   input  logic [31:0]       spr_dat_i,
   output logic [31:0]       spr_dat_o,
   output logic              spr_ack_o,
   input  logic [31:0]       match_rd_i,
   input  logic [31:0]       trans_rd_i,
   output immu_pkg::tlb_wr_t match_wr_o,
   output immu_pkg::tlb_wr_t trans_wr_o,
   output logic              tlb_access_o,
   output logic [21:0]       ptbr_o
);
   import immu_pkg::*;

   logic        group_sel;
   logic        ack_q;
   logic        first_cycle;
   logic        in_set;
   logic        immucr_cs;
   logic        match_cs;
   logic        trans_cs;
   logic        immucr_cs_q;
   logic        match_cs_q;
   logic        trans_cs_q;
   logic [31:0] immucr;

   assign group_sel   = spr_stb_i && (spr_addr_i[15:11] == SPR_GROUP_IMMU);
   assign first_cycle = group_sel && !ack_q;

   // Only the implemented sets are mapped, the rest of each range reads zero
   assign in_set = 32'(spr_addr_i[6:0]) < (32'd1 << SET_WIDTH);

   assign immucr_cs = group_sel && (spr_addr_i == SPR_IMMUCR_ADDR);
   assign match_cs  = group_sel && in_set &&
                      (spr_addr_i >= SPR_ITLB_MR_BASE) && (spr_addr_i < SPR_ITLB_TR_BASE);
   assign trans_cs  = group_sel && in_set &&
                      (spr_addr_i >= SPR_ITLB_TR_BASE) && (spr_addr_i < SPR_ITLB_END);

   // Ack one cycle into the access, for a single cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q       <= 1'b0;
         immucr_cs_q <= 1'b0;
         match_cs_q  <= 1'b0;
         trans_cs_q  <= 1'b0;
      end else begin
         ack_q       <= first_cycle;
         immucr_cs_q <= immucr_cs;
         match_cs_q  <= match_cs;
         trans_cs_q  <= trans_cs;
      end
   end

   assign spr_ack_o = ack_q && group_sel;

   always_ff @(posedge clk) begin
      if (rst) begin
         immucr <= '0;
      end else if (immucr_cs && first_cycle && spr_we_i) begin
         immucr <= spr_dat_i;
      end
   end

   assign ptbr_o = immucr[31:10];

   // Index rides along even without a write, the lookup reads with it
   always_comb begin
      match_wr_o                    = '0;
      match_wr_o.we                 = match_cs && first_cycle && spr_we_i;
      match_wr_o.idx[SET_WIDTH-1:0] = spr_addr_i[SET_WIDTH-1:0];
      match_wr_o.data               = spr_dat_i;
      trans_wr_o                    = match_wr_o;
      trans_wr_o.we                 = trans_cs && first_cycle && spr_we_i;
   end

   assign tlb_access_o = (match_cs || trans_cs) && first_cycle;

   always_comb begin
      if (match_cs_q) begin
         spr_dat_o = match_rd_i;
      end else if (trans_cs_q) begin
         spr_dat_o = trans_rd_i;
      end else if (immucr_cs_q) begin
         spr_dat_o = immucr;
      end else begin
         spr_dat_o = '0;
      end
   end

endmodule

`default_nettype wire

// File: immu_lookup.sv
`default_nettype none

module immu_lookup #(
   parameter int SET_WIDTH = 6
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [31:0]            fetch_addr_i,
   input  logic                   supervisor_mode_i,
   input  immu_pkg::tlb_wr_t      spr_match_wr_i,
   input  immu_pkg::tlb_wr_t      spr_trans_wr_i,
   input  immu_pkg::tlb_wr_t      reload_match_wr_i,
   input  immu_pkg::tlb_wr_t      reload_trans_wr_i,
   input  logic                   spr_access_i,
   input  logic [SET_WIDTH-1:0]   spr_index_i,
   output logic [31:0]            match_rd_o,
   output logic [31:0]            trans_rd_o,
   output logic [31:0]            match_addr_o,
   output immu_pkg::immu_result_t result_o
);
   import immu_pkg::*;

   tlb_wr_t              match_wr;
   tlb_wr_t              trans_wr;
   logic                 reload_wr;
   logic [SET_WIDTH-1:0] ram_addr;
   itlb_match_t          match_ent;
   itlb_trans_t          trans_ent;
   logic                 hit;

   // SPR writes win over the walker
   assign match_wr  = spr_match_wr_i.we ? spr_match_wr_i : reload_match_wr_i;
   assign trans_wr  = spr_trans_wr_i.we ? spr_trans_wr_i : reload_trans_wr_i;
   assign reload_wr = reload_match_wr_i.we || reload_trans_wr_i.we;

   always_comb begin
      if (spr_access_i) begin
         ram_addr = spr_index_i;
      end else if (reload_wr) begin
         ram_addr = reload_match_wr_i.idx[SET_WIDTH-1:0];
      end else begin
         ram_addr = fetch_addr_i[PAGE_BITS +: SET_WIDTH];
      end
   end

   tlb_ram #(
      .ADDR_WIDTH(SET_WIDTH),
      .DATA_WIDTH(32)
   ) u_match_ram (
      .clk   (clk),
      .addr_i(ram_addr),
      .we_i  (match_wr.we),
      .din_i (match_wr.data),
      .dout_o(match_rd_o)
   );

   tlb_ram #(
      .ADDR_WIDTH(SET_WIDTH),
      .DATA_WIDTH(32)
   ) u_trans_ram (
      .clk   (clk),
      .addr_i(ram_addr),
      .we_i  (trans_wr.we),
      .din_i (trans_wr.data),
      .dout_o(trans_rd_o)
   );

   // Aligns the tag with the synchronous RAM read
   always_ff @(posedge clk) begin
      if (rst) begin
         match_addr_o <= '0;
      end else begin
         match_addr_o <= fetch_addr_i;
      end
   end

   assign match_ent = match_rd_o;
   assign trans_ent = trans_rd_o;

   always_comb begin
      hit                    = match_ent.valid && (match_ent.vpn == match_addr_o[31:PAGE_BITS]);
      result_o.phys_addr     = {trans_ent.ppn, match_addr_o[PAGE_BITS-1:0]};
      result_o.cache_inhibit = trans_ent.ci;
      result_o.tlb_miss      = !hit;
      // No execute right for the current mode
      result_o.exec_fault    = hit && (supervisor_mode_i ? !trans_ent.sxe : !trans_ent.uxe);
   end

endmodule

`default_nettype wire

// File: immu_reload_walker.sv
`default_nettype none

module immu_reload_walker (
   input  logic              clk,
   input  logic              rst,
   input  logic              enable_i,
   input  logic              miss_i,
   input  logic [31:0]       match_addr_i,
   input  logic [21:0]       ptbr_i,
   output logic              busy_o,
   output logic              reload_req_o,
   output logic [31:0]       reload_addr_o,
   input  logic              reload_ack_i,
   input  logic [31:0]       reload_data_i,
   output logic              reload_pagefault_o,
   input  logic              reload_pagefault_clear_i,
   output immu_pkg::tlb_wr_t match_wr_o,
   output immu_pkg::tlb_wr_t trans_wr_o
);
   import immu_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_GET_PTR,
      S_GET_PTE,
      S_PROPAGATE
   } state_t;

   state_t      state;
   logic        do_reload;
   logic        fault_q;
   logic        wr_q;
   logic [31:0] vaddr_q;
   pt_word_u    pt_word;
   itlb_match_t match_data_q;
   itlb_trans_t trans_data_q;

   assign pt_word   = reload_data_i;
   assign do_reload = enable_i && miss_i && (ptbr_i != '0) && !fault_q;
   assign busy_o    = (state != S_IDLE) || do_reload;

   assign reload_pagefault_o = fault_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= S_IDLE;
         reload_req_o <= 1'b0;
         fault_q      <= 1'b0;
         wr_q         <= 1'b0;
      end else begin
         wr_q <= 1'b0;
         if (reload_pagefault_clear_i) begin
            fault_q <= 1'b0;
         end
         case (state)
            S_IDLE: begin
               if (do_reload) begin
                  reload_req_o <= 1'b1;
                  state        <= S_GET_PTR;
               end
            end
            // Request stays up into the table access
            S_GET_PTR: begin
               if (reload_ack_i) begin
                  if (pt_word.pgd.ptr == '0) begin
                     fault_q      <= 1'b1;
                     reload_req_o <= 1'b0;
                     state        <= S_IDLE;
                  end else begin
                     state <= S_GET_PTE;
                  end
               end
            end
            S_GET_PTE: begin
               if (reload_ack_i) begin
                  reload_req_o <= 1'b0;
                  if (!pt_word.pte.present) begin
                     fault_q <= 1'b1;
                     state   <= S_IDLE;
                  end else begin
                     wr_q  <= 1'b1;
                     state <= S_PROPAGATE;
                  end
               end
            end
            // New entry reaches the read ports
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Walk addresses and the refill words
   always_ff @(posedge clk) begin
      case (state)
         S_IDLE: begin
            vaddr_q       <= match_addr_i;
            reload_addr_o <= {ptbr_i, match_addr_i[31:24], 2'b00};
         end
         S_GET_PTR: begin
            if (reload_ack_i) begin
               reload_addr_o <= {pt_word.pgd.ptr, vaddr_q[23:PAGE_BITS], 2'b00};
            end
         end
         S_GET_PTE: begin
            match_data_q          <= '0;
            match_data_q.vpn      <= vaddr_q[31:PAGE_BITS];
            match_data_q.valid    <= 1'b1;
            trans_data_q          <= '0;
            trans_data_q.ppn      <= pt_word.pte.ppn;
            // User execute needs both x and u
            trans_data_q.uxe      <= pt_word.pte.x && pt_word.pte.u;
            trans_data_q.sxe      <= pt_word.pte.x;
            trans_data_q.dirty    <= pt_word.pte.d;
            trans_data_q.accessed <= pt_word.pte.a;
            trans_data_q.wom      <= pt_word.pte.wom;
            trans_data_q.wbc      <= pt_word.pte.wbc;
            trans_data_q.ci       <= pt_word.pte.ci;
            trans_data_q.cc       <= pt_word.pte.cc;
         end
         default: begin
         end
      endcase
   end

   always_comb begin
      match_wr_o.we   = wr_q;
      match_wr_o.idx  = vaddr_q[PAGE_BITS +: $bits(match_wr_o.idx)];
      match_wr_o.data = match_data_q;
      trans_wr_o.we   = wr_q;
      trans_wr_o.idx  = vaddr_q[PAGE_BITS +: $bits(trans_wr_o.idx)];
      trans_wr_o.data = trans_data_q;
   end

endmodule

`default_nettype wire

// File: immu_top.sv
`default_nettype none

module immu_top #(
   parameter int SET_WIDTH = 6
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        enable_i,
   input  logic        supervisor_mode_i,
   input  logic [31:0] fetch_addr_i,
   output logic [31:0] phys_addr_o,
   output logic        cache_inhibit_o,
   output logic        tlb_miss_o,
   output logic        pagefault_o,
   output logic        busy_o,
   input  logic        spr_stb_i,
   input  logic        spr_we_i,
   input  logic [15:0] spr_addr_i,
   input  logic [31:0] spr_dat_i,
   output logic [31:0] spr_dat_o,
   output logic        spr_ack_o,
   output logic        reload_req_o,
   output logic [31:0] reload_addr_o,
   input  logic        reload_ack_i,
   input  logic [31:0] reload_data_i,
   output logic        reload_pagefault_o,
   input  logic        reload_pagefault_clear_i
);
   import immu_pkg::*;

   tlb_wr_t      spr_match_wr;
   tlb_wr_t      spr_trans_wr;
   tlb_wr_t      reload_match_wr;
   tlb_wr_t      reload_trans_wr;
   logic         tlb_access;
   logic         walker_busy;
   logic [31:0]  match_rd;
   logic [31:0]  trans_rd;
   logic [31:0]  match_addr;
   logic [21:0]  ptbr;
   immu_result_t result;

   immu_spr_regs #(
      .SET_WIDTH(SET_WIDTH)
   ) u_spr (
      .clk         (clk),
      .rst         (rst),
      .spr_stb_i   (spr_stb_i),
      .spr_we_i    (spr_we_i),
      .spr_addr_i  (spr_addr_i),
      .spr_dat_i   (spr_dat_i),
      .spr_dat_o   (spr_dat_o),
      .spr_ack_o   (spr_ack_o),
      .match_rd_i  (match_rd),
      .trans_rd_i  (trans_rd),
      .match_wr_o  (spr_match_wr),
      .trans_wr_o  (spr_trans_wr),
      .tlb_access_o(tlb_access),
      .ptbr_o      (ptbr)
   );

   immu_lookup #(
      .SET_WIDTH(SET_WIDTH)
   ) u_lookup (
      .clk              (clk),
      .rst              (rst),
      .fetch_addr_i     (fetch_addr_i),
      .supervisor_mode_i(supervisor_mode_i),
      .spr_match_wr_i   (spr_match_wr),
      .spr_trans_wr_i   (spr_trans_wr),
      .reload_match_wr_i(reload_match_wr),
      .reload_trans_wr_i(reload_trans_wr),
      .spr_access_i     (tlb_access),
      .spr_index_i      (spr_match_wr.idx[SET_WIDTH-1:0]),
      .match_rd_o       (match_rd),
      .trans_rd_o       (trans_rd),
      .match_addr_o     (match_addr),
      .result_o         (result)
   );

   immu_reload_walker u_walker (
      .clk                     (clk),
      .rst                     (rst),
      .enable_i                (enable_i),
      .miss_i                  (result.tlb_miss),
      .match_addr_i            (match_addr),
      .ptbr_i                  (ptbr),
      .busy_o                  (walker_busy),
      .reload_req_o            (reload_req_o),
      .reload_addr_o           (reload_addr_o),
      .reload_ack_i            (reload_ack_i),
      .reload_data_i           (reload_data_i),
      .reload_pagefault_o      (reload_pagefault_o),
      .reload_pagefault_clear_i(reload_pagefault_clear_i),
      .match_wr_o              (reload_match_wr),
      .trans_wr_o              (reload_trans_wr)
   );

   assign busy_o = walker_busy || tlb_access;

   // Results are not valid while busy, a pending reload fault hides the miss
   assign phys_addr_o     = result.phys_addr;
   assign cache_inhibit_o = result.cache_inhibit;
   assign tlb_miss_o      = result.tlb_miss && !reload_pagefault_o && !busy_o;
   assign pagefault_o     = result.exec_fault && !busy_o;

endmodule

`default_nettype wire

// File: immu_asserts.sv
`default_nettype none

module immu_asserts (
   input logic clk,
   input logic rst,
   input logic spr_stb_i,
   input logic spr_ack_o,
   input logic reload_req_o,
   input logic reload_ack_i,
   input logic reload_pagefault_o,
   input logic busy_o
);

   // Ack answers a strobe once, in its second cycle
   ack_in_strobe: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o |-> spr_stb_i && $past(spr_stb_i) && !$past(spr_ack_o))
      else $error("spr_ack_o high outside the second cycle of a strobe");

   // Request is held until memory answers
   req_held: assert property (@(posedge clk) disable iff (rst)
      reload_req_o && !reload_ack_i |=> reload_req_o)
      else $error("reload_req_o dropped before reload_ack_i");

   quiet_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !spr_ack_o && !reload_req_o && !reload_pagefault_o && !busy_o)
      else $error("outputs active in the first cycle after reset");

endmodule

bind immu_top immu_asserts u_asserts (
   .clk               (clk),
   .rst               (rst),
   .spr_stb_i         (spr_stb_i),
   .spr_ack_o         (spr_ack_o),
   .reload_req_o      (reload_req_o),
   .reload_ack_i      (reload_ack_i),
   .reload_pagefault_o(reload_pagefault_o),
   .busy_o            (busy_o)
);

`default_nettype wire

// File: tb_immu.sv
`default_nettype none

module tb_immu;
   import immu_pkg::*;

   localparam int SET_W = 6;

   logic        clk;
   logic        rst;
   logic        enable;
   logic        supervisor_mode;
   logic [31:0] fetch_addr;
   logic [31:0] phys_addr;
   logic        cache_inhibit;
   logic        tlb_miss;
   logic        pagefault;
   logic        busy;
   logic        spr_stb;
   logic        spr_we;
   logic [15:0] spr_addr;
   logic [31:0] spr_wdata;
   logic [31:0] spr_rdata;
   logic        spr_ack;
   logic        reload_req;
   logic [31:0] reload_addr;
   logic        reload_ack;
   logic [31:0] reload_data;
   logic        reload_pagefault;
   logic        pf_clear;

   logic [31:0] rand_state;
   pt_word_u    pt_mem [logic [31:0]];
   logic [31:0] req_log [$];

   immu_top #(
      .SET_WIDTH(SET_W)
   ) UUT (
      .clk                     (clk),
      .rst                     (rst),
      .enable_i                (enable),
      .supervisor_mode_i       (supervisor_mode),
      .fetch_addr_i            (fetch_addr),
      .phys_addr_o             (phys_addr),
      .cache_inhibit_o         (cache_inhibit),
      .tlb_miss_o              (tlb_miss),
      .pagefault_o             (pagefault),
      .busy_o                  (busy),
      .spr_stb_i               (spr_stb),
      .spr_we_i                (spr_we),
      .spr_addr_i              (spr_addr),
      .spr_dat_i               (spr_wdata),
      .spr_dat_o               (spr_rdata),
      .spr_ack_o               (spr_ack),
      .reload_req_o            (reload_req),
      .reload_addr_o           (reload_addr),
      .reload_ack_i            (reload_ack),
      .reload_data_i           (reload_data),
      .reload_pagefault_o      (reload_pagefault),
      .reload_pagefault_clear_i(pf_clear)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rand_state = xorshift32(rand_state);
      return rand_state;
   endfunction

   task automatic abort_run();
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   // Page-table memory that acks each request after 0 to 3 idle cycles
   initial begin : pt_memory
      logic [31:0] delay_state;
      logic [31:0] addr;
      pt_word_u    word;
      delay_state = xorshift32(32'hd596);
      reload_ack  = 1'b0;
      reload_data = '0;
      forever begin
         @(negedge clk);
         if (reload_req) begin
            addr = reload_addr;
            req_log.push_back(addr);
            word = '0;
            if (pt_mem.exists(addr)) begin
               word = pt_mem[addr];
            end
            delay_state = xorshift32(delay_state);
            repeat (delay_state[1:0]) @(posedge clk);
            @(posedge clk);
            reload_ack  <= 1'b1;
            reload_data <= word;
            @(posedge clk);
            reload_ack <= 1'b0;
         end
      end
   end

   task automatic spr_access(input logic we, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int edges;
      edges = 0;
      @(posedge clk);
      spr_stb   <= 1'b1;
      spr_we    <= we;
      spr_addr  <= addr;
      spr_wdata <= wdata;
      @(negedge clk);
      while (!spr_ack) begin
         @(negedge clk);
         edges++;
         if (edges > 8) begin
            $display("SPR access to address %h was never acknowledged", addr);
            abort_run();
         end
      end
      rdata = spr_rdata;
      @(posedge clk);
      spr_stb <= 1'b0;
      spr_we  <= 1'b0;
      check("spr ack latency", 32'd1, 32'(edges));
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      spr_access(1'b1, addr, data, unused);
   endtask

   task automatic spr_read(input logic [15:0] addr, output logic [31:0] data);
      spr_access(1'b0, addr, 32'd0, data);
   endtask

   task automatic load_entry(input logic [18:0] vpn, input logic [18:0] ppn,
                             input logic uxe, input logic sxe, input logic ci);
      itlb_match_t m;
      itlb_trans_t t;
      m       = '0;
      m.vpn   = vpn;
      m.valid = 1'b1;
      t       = '0;
      t.ppn   = ppn;
      t.uxe   = uxe;
      t.sxe   = sxe;
      t.ci    = ci;
      spr_write(SPR_ITLB_MR_BASE + 16'(vpn[SET_W-1:0]), m);
      spr_write(SPR_ITLB_TR_BASE + 16'(vpn[SET_W-1:0]), t);
   endtask

   // Result of a fetch address is stable half a cycle after the capturing edge
   task automatic present(input logic [31:0] addr);
      @(posedge clk);
      fetch_addr <= addr;
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic start_walk(input logic [31:0] vaddr);
      int n;
      n = 0;
      spr_write(SPR_ITLB_MR_BASE + 16'(vaddr[PAGE_BITS +: SET_W]), 32'd0);
      present(vaddr);
      req_log.delete();
      @(posedge clk);
      enable <= 1'b1;
      @(negedge clk);
      check("walk busy", 32'd1, 32'(busy));
      while (busy) begin
         @(negedge clk);
         n++;
         if (n > 40) begin
            $display("Page-table walk for %h never finished", vaddr);
            abort_run();
         end
      end
   endtask

   task automatic spr_round_trip();
      logic [31:0] v;
      logic [31:0] rd;
      logic [5:0]  set;
      v = next_random();
      spr_write(SPR_IMMUCR_ADDR, v);
      spr_read(SPR_IMMUCR_ADDR, rd);
      check("spr_round_trip immucr", v, rd);
      set = 6'(next_random());
      v = next_random();
      spr_write(SPR_ITLB_MR_BASE + 16'(set), v);
      spr_read(SPR_ITLB_MR_BASE + 16'(set), rd);
      check("spr_round_trip match", v, rd);
      v = next_random();
      spr_write(SPR_ITLB_TR_BASE + 16'(set), v);
      spr_read(SPR_ITLB_TR_BASE + 16'(set), rd);
      check("spr_round_trip translate", v, rd);
      // Sets past the implemented count are not mapped
      spr_write(SPR_ITLB_MR_BASE + 16'h40 + 16'(set), next_random());
      spr_read(SPR_ITLB_MR_BASE + 16'h40 + 16'(set), rd);
      check("spr_round_trip unmapped set", 32'd0, rd);
      spr_read(16'h1001, rd);
      check("spr_round_trip unmapped 1001", 32'd0, rd);
      spr_read(SPR_ITLB_END, rd);
      check("spr_round_trip unmapped end", 32'd0, rd);
      spr_write(SPR_IMMUCR_ADDR, 32'd0);
   endtask

   task automatic hit_translation();
      logic [31:0] r;
      logic [31:0] r2;
      r  = next_random();
      r2 = next_random();
      load_entry(r[31:13], r2[18:0], 1'b1, 1'b1, r2[31]);
      present(r);
      check("hit_translation phys", {r2[18:0], r[12:0]}, phys_addr);
      check("hit_translation ci", 32'(r2[31]), 32'(cache_inhibit));
      check("hit_translation miss", 32'd0, 32'(tlb_miss));
      check("hit_translation fault", 32'd0, 32'(pagefault));
   endtask

   task automatic miss_without_reload();
      logic [31:0] r;
      spr_write(SPR_IMMUCR_ADDR, 32'd0);
      @(posedge clk);
      enable <= 1'b1;
      r = next_random();
      spr_write(SPR_ITLB_MR_BASE + 16'(r[PAGE_BITS +: SET_W]), 32'd0);
      present(r);
      check("miss_without_reload invalid", 32'd1, 32'(tlb_miss));
      // Same set with another tag
      load_entry(r[31:13] ^ 19'h40000, 19'(next_random()), 1'b1, 1'b1, 1'b0);
      present(r);
      check("miss_without_reload tag", 32'd1, 32'(tlb_miss));
      repeat (4) begin
         @(negedge clk);
         check("miss_without_reload busy", 32'd0, 32'(busy));
         check("miss_without_reload req", 32'd0, 32'(reload_req));
      end
      @(posedge clk);
      enable <= 1'b0;
   endtask

   task automatic hardware_reload();
      logic [31:0] vaddr;
      logic [31:0] r;
      logic [21:0] ptbr;
      logic [18:0] ptr;
      logic [31:0] pgd_addr;
      logic [31:0] pte_addr;
      logic [31:0] rd;
      pt_word_u    w;
      pte_t        pte;
      itlb_match_t m;
      itlb_trans_t t;
      vaddr    = next_random();
      r        = next_random();
      ptbr     = {2'b10, r[19:0]};
      ptr      = {2'b11, r[31:15]};
      pgd_addr = {ptbr, vaddr[31:24], 2'b00};
      pte_addr = {ptr, vaddr[23:13], 2'b00};
      w         = '0;
      w.pgd.ptr = ptr;
      pt_mem[pgd_addr] = w;
      r           = next_random();
      pte         = '0;
      pte.ppn     = r[31:13];
      pte.present = 1'b1;
      pte.x       = r[8];
      pte.u       = r[0];
      pte.w       = r[1];
      {pte.d, pte.a, pte.wom, pte.wbc, pte.ci, pte.cc} = r[7:2];
      w.pte = pte;
      pt_mem[pte_addr] = w;
      spr_write(SPR_IMMUCR_ADDR, {ptbr, 10'd0});
      start_walk(vaddr);
      @(posedge clk);
      enable <= 1'b0;
      check("hardware_reload requests", 32'd2, 32'(req_log.size()));
      check("hardware_reload pgd addr", pgd_addr, req_log[0]);
      check("hardware_reload pte addr", pte_addr, req_log[1]);
      check("hardware_reload fault", 32'd0, 32'(reload_pagefault));
      present(vaddr);
      check("hardware_reload miss", 32'd0, 32'(tlb_miss));
      check("hardware_reload phys", {pte.ppn, vaddr[12:0]}, phys_addr);
      check("hardware_reload ci", 32'(pte.ci), 32'(cache_inhibit));
      m       = '0;
      m.vpn   = vaddr[31:13];
      m.valid = 1'b1;
      t       = '0;
      t.ppn   = pte.ppn;
      t.sxe   = pte.x;
      t.uxe   = pte.x & pte.u;
      {t.dirty, t.accessed, t.wom, t.wbc, t.ci, t.cc} = {pte.d, pte.a, pte.wom, pte.wbc,
                                                          pte.ci, pte.cc};
      spr_read(SPR_ITLB_MR_BASE + 16'(vaddr[PAGE_BITS +: SET_W]), rd);
      check("hardware_reload match reg", m, rd);
      spr_read(SPR_ITLB_TR_BASE + 16'(vaddr[PAGE_BITS +: SET_W]), rd);
      check("hardware_reload translate reg", t, rd);
   endtask

   task automatic fault_case(input string name, input logic zero_ptr);
      logic [31:0] vaddr;
      logic [31:0] r;
      logic [21:0] ptbr;
      logic [18:0] ptr;
      pt_word_u    w;
      vaddr = next_random();
      r     = next_random();
      ptbr  = {2'b10, r[19:0]};
      ptr   = zero_ptr ? 19'd0 : {2'b11, r[31:15]};
      w         = '0;
      w.pgd.ptr = ptr;
      pt_mem[{ptbr, vaddr[31:24], 2'b00}] = w;
      // Entry with present clear but otherwise plausible
      w         = '0;
      w.pte.ppn = r[18:0];
      w.pte.x   = 1'b1;
      pt_mem[{ptr, vaddr[23:13], 2'b00}] = w;
      spr_write(SPR_IMMUCR_ADDR, {ptbr, 10'd0});
      start_walk(vaddr);
      check(name, zero_ptr ? 32'd1 : 32'd2, 32'(req_log.size()));
      repeat (4) begin
         @(negedge clk);
         check(name, 32'd1, 32'(reload_pagefault));
         check(name, 32'd0, 32'(tlb_miss));
         check(name, 32'd0, 32'(busy));
         check(name, 32'd0, 32'(reload_req));
      end
      @(posedge clk);
      enable   <= 1'b0;
      pf_clear <= 1'b1;
      @(posedge clk);
      pf_clear <= 1'b0;
      @(negedge clk);
      check(name, 32'd0, 32'(reload_pagefault));
      check(name, 32'd1, 32'(tlb_miss));
   endtask

   task automatic reload_page_faults();
      fault_case("reload_page_faults zero pointer", 1'b1);
      fault_case("reload_page_faults not present", 1'b0);
      spr_write(SPR_IMMUCR_ADDR, 32'd0);
   endtask

   task automatic exec_permission();
      logic [31:0] r;
      logic        expect_fault;
      for (int p = 0; p < 4; p++) begin
         r = next_random();
         load_entry(r[31:13], r[18:0], p[1], p[0], 1'b0);
         for (int m = 0; m < 2; m++) begin
            @(posedge clk);
            supervisor_mode <= m[0];
            present(r);
            expect_fault = m[0] ? !p[0] : !p[1];
            check("exec_permission miss", 32'd0, 32'(tlb_miss));
            check("exec_permission fault", 32'(expect_fault), 32'(pagefault));
         end
      end
      @(posedge clk);
      supervisor_mode <= 1'b1;
   endtask

   initial begin
      rst             = 1'b1;
      enable          = 1'b0;
      supervisor_mode = 1'b1;
      fetch_addr      = '0;
      spr_stb         = 1'b0;
      spr_we          = 1'b0;
      spr_addr        = '0;
      spr_wdata       = '0;
      pf_clear        = 1'b0;
      rand_state      = 32'hd596;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      spr_round_trip();
      hit_translation();
      miss_without_reload();
      hardware_reload();
      reload_page_faults();
      exec_permission();
      @(negedge clk);
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
immu_pkg.sv
tlb_ram.sv
immu_spr_regs.sv
immu_lookup.sv
immu_reload_walker.sv
immu_top.sv
immu_asserts.sv
tb_immu.sv

// File: run.sh
#!/bin/sh
# Build and run the IMMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_immu -f all.f -o tb_immu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_immu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

printf '%s\n' "$out" | grep -qxF '** PASS **' || exit 1
exit 0
